// File: Makefile
# Verilator build, run, lint and clean for the single-cycle MIPS core

VERILATOR   ?= verilator
TOP         ?= mipsTb
DUT_TOP     ?= mipsCore
FILELIST    ?= filelist.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS  ?= --lint-only -Wall
PASS_TEXT   ?= Simulation PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) hdl/mipsPkg.sv hdl/fetchStage.sv hdl/regFile.sv \
		hdl/decodeStage.sv hdl/executeStage.sv hdl/mipsCore.sv --top-module $(DUT_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
hdl/mipsPkg.sv
hdl/fetchStage.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/mipsCore.sv
tests/mipsCore_assertions.sv
tests/mipsTb.sv

// File: hdl/decodeStage.sv
// decode stage of the single-cycle core
// main control and ALU operation decode
// immediate sign extension, destination select
// writeback data select and reset gating of the write strobes
// register file instance
`timescale 1ns/10ps

module decodeStage import mipsPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  instrT       instr,
  input  logic [31:0] pcPlus4,
  input  exResultT    ex,
  input  logic [31:0] memReadData,
  output decodeT      dec,
  output wbT          wb,
  output logic        memWriteEn
);

  ctrlT        ctrl;
  aluOpT       aluOp;
  logic [31:0] immExt;
  logic [31:0] rsData;
  logic [31:0] rtData;
  logic [4:0]  destAddr;
  logic [31:0] wbData;

  // ============================================================
  // control decode
  // ============================================================
  always_comb begin
    ctrl  = '0;
    aluOp = aluAdd;
    case (instr.rType.opcode)
      opR: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        case (instr.rType.funct)
          fnAdd:   aluOp = aluAdd;
          fnSub:   aluOp = aluSub;
          fnAnd:   aluOp = aluAnd;
          fnOr:    aluOp = aluOr;
          fnSlt:   aluOp = aluSlt;
          // unsupported funct behaves as nop
          default: ctrl = '0;
        endcase
      end
      opLw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      opSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      opBeq: begin
        // compare by subtraction
        ctrl.branch = 1'b1;
        aluOp       = aluSub;
      end
      opJ: ctrl.jump = 1'b1;
      opJal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

  // 16-bit immediate, sign extended
  assign immExt = {{16{instr.iType.imm[15]}}, instr.iType.imm};

  regFile uRegFile (
    .clk    (clk),
    .rst    (rst),
    .rsAddr (instr.rType.rs),
    .rtAddr (instr.rType.rt),
    .wb     (wb),
    .rsData (rsData),
    .rtData (rtData)
  );

  // operands and controls on to execute
  assign dec.rsData = rsData;
  assign dec.rtData = rtData;
  assign dec.immExt = immExt;
  assign dec.aluOp  = aluOp;
  assign dec.ctrl   = ctrl;

  // ============================================================
  // writeback
  // ============================================================
  // rd for R-type, rt for loads, r31 for jal
  assign destAddr = ctrl.link ? raLink : (ctrl.regDst ? instr.rType.rd : instr.rType.rt);

  always_comb begin
    if (ctrl.link) begin
      wbData = pcPlus4;
    end else if (ctrl.memToReg) begin
      wbData = memReadData;
    end else begin
      wbData = ex.aluResult;
    end
  end

  // no strobe while in reset, r0 destination dropped here
  assign wb.en       = rst && ctrl.regWrite && (destAddr != 5'd0);
  assign wb.addr     = destAddr;
  assign wb.data     = wbData;
  assign memWriteEn  = rst && ctrl.memWrite;

endmodule

// File: hdl/executeStage.sv
// execute stage of the single-cycle core
// second operand select, ALU with signed set-less-than
// beq decision and word-aligned branch offset
`timescale 1ns/10ps

module executeStage import mipsPkg::*; (
  input  decodeT   dec,
  output exResultT ex
);

  logic [31:0] opA;
  logic [31:0] opB;
  logic [31:0] diff;
  logic [31:0] result;
  logic        lessThan;

  // operand select, immediate for lw and sw
  assign opA = dec.rsData;
  assign opB = dec.ctrl.aluSrc ? dec.immExt : dec.rtData;

  // shared by sub and the beq compare
  assign diff = opA - opB;

  // signed compare for slt
  assign lessThan = $signed(opA) < $signed(opB);

  // ============================================================
  // ALU
  // ============================================================
  always_comb begin
    case (dec.aluOp)
      aluAdd:  result = opA + opB;
      aluSub:  result = diff;
      aluAnd:  result = opA & opB;
      aluOr:   result = opA | opB;
      aluSlt:  result = {31'd0, lessThan};
      default: result = opA + opB;
    endcase
  end

  assign ex.aluResult = result;

  // operands equal means a taken beq
  assign ex.takeBranch = dec.ctrl.branch && (diff == 32'd0);

  // immediate times four, fetch adds PC+4
  assign ex.branchOffset = {dec.immExt[29:0], 2'b00};

endmodule

// File: hdl/fetchStage.sv
// fetch stage of the single-cycle core
// program counter register with asynchronous clear
// next-PC select between jump, taken branch and PC+4
`timescale 1ns/10ps

module fetchStage import mipsPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  ctrlT        ctrl,
  input  logic [25:0] jumpTarget,
  input  exResultT    ex,
  output logic [31:0] pc,
  output logic [31:0] pcPlus4
);

  logic [31:0] jumpAddr;
  logic [31:0] branchAddr;
  logic [31:0] nextPc;

  // sequential flow, also the jal link value
  assign pcPlus4 = pc + 32'd4;

  // pseudo-direct jump, region bits from PC+4
  assign jumpAddr = {pcPlus4[31:28], jumpTarget, 2'b00};

  // branch target relative to the delay-free PC+4
  assign branchAddr = pcPlus4 + ex.branchOffset;

  // jump wins over branch, they never both decode anyway
  always_comb begin
    if (ctrl.jump) begin
      nextPc = jumpAddr;
    end else if (ex.takeBranch) begin
      nextPc = branchAddr;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // pc register, zero out of reset
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

// File: hdl/mipsCore.sv
// top level of the single-cycle MIPS core
// chains fetch, decode and execute inside one clock cycle
// instruction fetch port, data memory port, writeback port
`timescale 1ns/10ps

module mipsCore import mipsPkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  output logic [31:0]             instrAddr,
  input  instrT                   instr,
  output logic [dataAddrBits-1:0] memAddr,
  output logic [31:0]             memWriteData,
  output logic                    memWriteEn,
  input  logic [31:0]             memReadData,
  output wbT                      wb
);

  logic [31:0] pcPlus4;
  decodeT      dec;
  exResultT    ex;

  // pc drives the instruction memory directly
  fetchStage uFetch (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (dec.ctrl),
    .jumpTarget (instr.jType.target),
    .ex         (ex),
    .pc         (instrAddr),
    .pcPlus4    (pcPlus4)
  );

  decodeStage uDecode (
    .clk         (clk),
    .rst         (rst),
    .instr       (instr),
    .pcPlus4     (pcPlus4),
    .ex          (ex),
    .memReadData (memReadData),
    .dec         (dec),
    .wb          (wb),
    .memWriteEn  (memWriteEn)
  );

  executeStage uExecute (
    .dec (dec),
    .ex  (ex)
  );

  // word address into data memory, byte offset dropped
  assign memAddr      = ex.aluResult[dataAddrBits+1:2];
  assign memWriteData = dec.rtData;

endmodule

// File: hdl/mipsPkg.sv
// shared definitions for the single-cycle MIPS core
// opcode and funct encodings, link register index, data address width
// ALU operation codes, instruction word views
// control and stage-to-stage structs, writeback port struct
package mipsPkg;

  // ============================================================
  // encodings
  // ============================================================
  // primary opcodes, instr[31:26]
  localparam logic [5:0] opR   = 6'b000000;
  localparam logic [5:0] opLw  = 6'b100011;
  localparam logic [5:0] opSw  = 6'b101011;
  localparam logic [5:0] opBeq = 6'b000100;
  localparam logic [5:0] opJ   = 6'b000010;
  localparam logic [5:0] opJal = 6'b000011;

  // R-type funct field, instr[5:0]
  localparam logic [5:0] fnAdd = 6'b100000;
  localparam logic [5:0] fnSub = 6'b100010;
  localparam logic [5:0] fnAnd = 6'b100100;
  localparam logic [5:0] fnOr  = 6'b100101;
  localparam logic [5:0] fnSlt = 6'b101010;

  // jal return address goes here
  localparam logic [4:0] raLink = 5'd31;

  // 128-word data memory
  localparam int dataAddrBits = 7;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt
  } aluOpT;

  // ============================================================
  // instruction word, three views of the same 32 bits
  // ============================================================
  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } rType;
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
    } iType;
    struct packed {
      logic [5:0]  opcode;
      logic [25:0] target;
    } jType;
  } instrT;

  // main control bits, one set per instruction
  typedef struct packed {
    logic regDst;
    logic aluSrc;
    logic memToReg;
    logic regWrite;
    logic memWrite;
    logic branch;
    logic jump;
    logic link;
  } ctrlT;

  // decode to execute
  typedef struct packed {
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] immExt;
    aluOpT       aluOp;
    ctrlT        ctrl;
  } decodeT;

  // execute to fetch and memory
  // branchOffset is already shifted left by two
  typedef struct packed {
    logic [31:0] aluResult;
    logic        takeBranch;
    logic [31:0] branchOffset;
  } exResultT;

  // register file write port, also visible at the top
  typedef struct packed {
    logic        en;
    logic [4:0]  addr;
    logic [31:0] data;
  } wbT;

endpackage

// File: hdl/regFile.sv
// 32 x 32-bit register file
// two combinational read ports, one clocked write port
// register 0 reads as zero and ignores writes
`timescale 1ns/10ps

module regFile import mipsPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rsAddr,
  input  logic [4:0]  rtAddr,
  input  wbT          wb,
  output logic [31:0] rsData,
  output logic [31:0] rtData
);

  logic [31:0] regs [32];

  // write on the rising edge, whole array cleared on reset
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && (wb.addr != 5'd0)) begin
      regs[wb.addr] <= wb.data;
    end
  end

  // reads see the old value until the edge
  // hard zero for r0
  assign rsData = (rsAddr == 5'd0) ? 32'd0 : regs[rsAddr];
  assign rtData = (rtAddr == 5'd0) ? 32'd0 : regs[rtAddr];

endmodule

// File: tests/mipsCore_assertions.sv
// concurrent assertions on the core's outputs
// write strobes quiet in reset, aligned fetch address,
// no writeback strobe towards register 0
`timescale 1ns/10ps

module mipsCoreAssertions import mipsPkg::*; (
  input logic        clk,
  input logic        rst,
  input logic [31:0] instrAddr,
  input logic        memWriteEn,
  input wbT          wb
);

  // nothing gets written while reset is held
  assert property (@(posedge clk) !rst |-> (!memWriteEn && !wb.en))
    else $error("write strobe active during reset");

  // fetch address on a word boundary
  assert property (@(posedge clk) instrAddr[1:0] == 2'b00)
    else $error("instruction address not word aligned");

  // r0 writes are dropped in decode
  assert property (@(posedge clk) disable iff (!rst) wb.en |-> (wb.addr != 5'd0))
    else $error("writeback strobe aimed at register 0");

endmodule

bind mipsCore mipsCoreAssertions uAssert (
  .clk        (clk),
  .rst        (rst),
  .instrAddr  (instrAddr),
  .memWriteEn (memWriteEn),
  .wb         (wb)
);

// File: tests/mipsTb.sv
// testbench for the single-cycle MIPS core
// clock and reset, instruction ROM and data memory models
// random program generator with a fixed seed
// instruction-level reference model stepped once per cycle
// compare tasks for PC, writeback and store port
`timescale 1ns/10ps

module mipsTb import mipsPkg::*; ();

  localparam int clkPeriod = 100;
  localparam int runCycles = 2000;

  logic                    clk;
  logic                    rst;
  logic [31:0]             instrAddr;
  instrT                   instr;
  logic [dataAddrBits-1:0] memAddr;
  logic [31:0]             memWriteData;
  logic                    memWriteEn;
  logic [31:0]             memReadData;
  wbT                      wb;

  // memories seen by the DUT
  instrT       rom [256];
  logic [31:0] dmem [128];

  // reference model state
  logic [31:0] mRegs [32];
  logic [31:0] mMem [128];
  logic [31:0] mPc;

  integer seed;

  mipsCore UUT (
    .clk          (clk),
    .rst          (rst),
    .instrAddr    (instrAddr),
    .instr        (instr),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .memWriteEn   (memWriteEn),
    .memReadData  (memReadData),
    .wb           (wb)
  );

  // ============================================================
  // clock and memory models
  // ============================================================
  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // combinational word-addressed reads
  assign instr       = rom[instrAddr[9:2]];
  assign memReadData = dmem[memAddr];

  always @(posedge clk) begin
    if (memWriteEn) begin
      dmem[memAddr] <= memWriteData;
    end
  end

  // ============================================================
  // failure reporting and compare tasks
  // ============================================================
  task automatic reportFailure(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic checkPc(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %h actual %h", name, expected, actual);
      reportFailure("instruction address differs from the model");
    end
  endtask

  task automatic checkWb(input string name, input wbT expected, input wbT actual);
    logic bad;
    bad = (actual.en !== expected.en);
    // addr and data only matter with the strobe up
    if (expected.en && ((actual.addr !== expected.addr) || (actual.data !== expected.data))) begin
      bad = 1'b1;
    end
    if (bad) begin
      $display("CHECK FAILED %s: expected en=%b addr=%0d data=%h actual en=%b addr=%0d data=%h",
               name, expected.en, expected.addr, expected.data,
               actual.en, actual.addr, actual.data);
      reportFailure("register writeback differs from the model");
    end
  endtask

  task automatic checkStore(input string name, input logic expEn,
                            input logic [dataAddrBits-1:0] expAddr, input logic [31:0] expData,
                            input logic actEn, input logic [dataAddrBits-1:0] actAddr,
                            input logic [31:0] actData);
    if ((actEn !== expEn) || (expEn && ((actAddr !== expAddr) || (actData !== expData)))) begin
      $display("CHECK FAILED %s: expected en=%b addr=%0d data=%h actual en=%b addr=%0d data=%h",
               name, expEn, expAddr, expData, actEn, actAddr, actData);
      reportFailure("data memory store differs from the model");
    end
  endtask

  // ============================================================
  // program generation
  // ============================================================
  function automatic int randBelow(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // forward-only branches and jumps
  // last word loops back to 0
  task automatic buildProgram();
    instrT ins;
    int    kind;
    int    target;
    for (int i = 0; i < 256; i++) begin
      ins = '0;
      // straight-line R-type right after reset
      kind = (i < 8) ? 0 : randBelow(10);
      target = i + 1 + randBelow(8);
      if (target > 255) begin
        target = 255;
      end
      ins.rType.rs = 5'(randBelow(8));
      ins.rType.rt = 5'(randBelow(8));
      case (kind)
        4, 5: begin
          ins.iType.opcode = (kind == 4) ? opLw : opSw;
          ins.iType.rs     = 5'd0;
          ins.iType.imm    = 16'(randBelow(16) * 4);
        end
        6: begin
          ins.iType.opcode = opBeq;
          ins.iType.imm    = 16'(target - i - 1);
        end
        7, 8: begin
          ins.jType.opcode = (kind == 7) ? opJ : opJal;
          ins.jType.target = 26'(target);
        end
        default: begin
          ins.rType.opcode = opR;
          ins.rType.rd     = 5'(randBelow(8));
          case (randBelow(5))
            0:       ins.rType.funct = fnAdd;
            1:       ins.rType.funct = fnSub;
            2:       ins.rType.funct = fnAnd;
            3:       ins.rType.funct = fnOr;
            default: ins.rType.funct = fnSlt;
          endcase
        end
      endcase
      if (i == 255) begin
        ins = '0;
        ins.jType.opcode = opJ;
      end
      rom[i] = ins;
    end
    for (int i = 0; i < 128; i++) begin
      mMem[i] = $random(seed);
      dmem[i] <= mMem[i];
    end
    for (int i = 0; i < 32; i++) begin
      mRegs[i] = 32'd0;
    end
    mPc = 32'd0;
  endtask

  // ============================================================
  // reference model stepping one instruction per call
  // ============================================================
  task automatic stepModel();
    instrT                   ins;
    logic [31:0]             rsV;
    logic [31:0]             rtV;
    logic [31:0]             immExt;
    logic [31:0]             pc4;
    logic [31:0]             addr;
    logic [31:0]             nextPc;
    wbT                      expWb;
    logic                    expEn;
    logic [dataAddrBits-1:0] expAddr;
    logic [31:0]             expData;
    ins     = rom[mPc[9:2]];
    rsV     = mRegs[ins.rType.rs];
    rtV     = mRegs[ins.rType.rt];
    immExt  = {{16{ins.iType.imm[15]}}, ins.iType.imm};
    pc4     = mPc + 32'd4;
    addr    = rsV + immExt;
    nextPc  = pc4;
    expWb   = '0;
    expEn   = 1'b0;
    expAddr = '0;
    expData = '0;
    checkPc("fetch address", mPc, instrAddr);
    case (ins.rType.opcode)
      opR: begin
        expWb.addr = ins.rType.rd;
        expWb.en   = (ins.rType.rd != 5'd0);
        case (ins.rType.funct)
          fnAdd:   expWb.data = rsV + rtV;
          fnSub:   expWb.data = rsV - rtV;
          fnAnd:   expWb.data = rsV & rtV;
          fnOr:    expWb.data = rsV | rtV;
          default: expWb.data = ($signed(rsV) < $signed(rtV)) ? 32'd1 : 32'd0;
        endcase
      end
      opLw: begin
        expWb.addr = ins.iType.rt;
        expWb.en   = (ins.iType.rt != 5'd0);
        expWb.data = mMem[addr[8:2]];
      end
      opSw: begin
        expEn   = 1'b1;
        expAddr = addr[8:2];
        expData = rtV;
      end
      opBeq: begin
        if (rsV == rtV) begin
          nextPc = pc4 + (immExt << 2);
        end
      end
      default: begin
        // j and jal
        nextPc = {pc4[31:28], ins.jType.target, 2'b00};
        if (ins.jType.opcode == opJal) begin
          expWb = '{en: 1'b1, addr: 5'd31, data: pc4};
        end
      end
    endcase
    checkWb("writeback", expWb, wb);
    checkStore("store", expEn, expAddr, expData, memWriteEn, memAddr, memWriteData);
    if (expWb.en) begin
      mRegs[expWb.addr] = expWb.data;
    end
    if (expEn) begin
      mMem[expAddr] = expData;
    end
    mPc = nextPc;
  endtask

  task automatic waitResetRelease();
    int waited;
    waited = 0;
    @(negedge clk);
    while (rst !== 1'b1) begin
      if (waited >= 10) begin
        reportFailure("reset was not released within 10 cycles");
      end
      waited++;
      @(negedge clk);
    end
  endtask

  // ============================================================
  // main sequence
  // ============================================================
  initial begin
    rst  <= 1'b0;
    seed = 42;
    buildProgram();
    // outputs quiet and PC at zero for 3 reset cycles
    repeat (3) begin
      @(negedge clk);
      checkPc("reset pc", 32'd0, instrAddr);
      checkWb("reset writeback", '0, wb);
      checkStore("reset store", 1'b0, '0, '0, memWriteEn, memAddr, memWriteData);
      @(posedge clk);
    end
    rst <= 1'b1;
    waitResetRelease();
    for (int cycle = 0; cycle < runCycles; cycle++) begin
      stepModel();
      @(negedge clk);
    end
    $display("Simulation PASSED");
    $finish;
  end

  // watchdog against a stuck run
  initial begin
    #(clkPeriod * (runCycles + 50));
    reportFailure("run did not finish in the expected time");
  end

endmodule
